// File: flist.f
design/mem_stage_pkg.sv
design/mem_stage_reg.sv
design/store_data_unit.sv
design/mem_access_ctrl.sv
design/wb_result_unit.sv
design/mem_stage_top.sv
tests/tb_clock_gen.sv
tests/tb_mem_stage.sv

// File: run_sim.sh
#!/bin/sh
# build and run the memory-access stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module tb_mem_stage -f flist.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { echo "build or run error"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || grep -q "Simulation passed" sim.log || exit 1
exit 0

// File: tests/tb_mem_stage.sv
/*
 * testbench for the memory-access stage
 * random EX items, dword memory model with random latency,
 * reference model of the write-back and store formatting, watchdog
 */

`timescale 1ns/10ps
`default_nettype none

module tb_mem_stage;

    localparam int  N_ITEMS    = 200;
    localparam int  RST_CYCLES = 10;
    localparam int  PERIOD     = 100;
    localparam time WD_LIMIT   = (RST_CYCLES + N_ITEMS * 8) * PERIOD;

    typedef struct packed {
        mem_stage_pkg::ex_mem_t item;
        mem_stage_pkg::wb_fwd_t fwd;     // forwarding seen while item is held
    } item_rec_t;

    typedef struct packed {
        mem_stage_pkg::reg_wr_t reg_wr;
        logic [63:0]            addr;
        logic                   wen;
        logic [63:0]            wdata;   // only strobed lanes are meaningful
        logic [7:0]             wstrb;
    } exp_t;

    logic                      clk;
    logic                      rst;
    logic                      in_valid;
    mem_stage_pkg::ex_mem_t    in_data;
    logic                      in_ready;
    logic                      out_valid;
    mem_stage_pkg::mem_wb_t    out_data;
    logic                      out_ready;
    mem_stage_pkg::wb_fwd_t    wb_fwd;
    logic                      dmem_req_valid;
    mem_stage_pkg::dmem_req_t  dmem_req;
    logic                      dmem_rsp_valid;
    logic [63:0]               dmem_rsp_rdata;

    // ******************************
    // scoreboard state
    // ******************************
    item_rec_t     acc_q[$];       // every accepted item, in order
    item_rec_t     memq[$];        // memory items still to request
    logic [63:0]   snap_q[$];      // dword seen by each request
    logic [63:0]   mem [0:31];     // 256 byte window
    logic [15:0]   lfsr_state = 16'd54737;
    mem_stage_pkg::wb_fwd_t drv_fwd;
    logic          took_item = 1'b0;
    logic          outstanding = 1'b0;
    logic          mem_busy = 1'b0;      // memory item held, response not yet in
    logic          rsp_pending = 1'b0;
    int            rsp_lat = 0;
    logic [63:0]   rsp_data = '0;
    logic          first_in_seen = 1'b0;
    int            gen_cnt = 0;
    int            done_cnt = 0;
    int            mem_items = 0;
    int            req_cnt = 0;
    int            chk_errs = 0;
    int            proto_errs = 0;

    tb_clock_gen #(.PERIOD(PERIOD), .RST_CYCLES(RST_CYCLES)) tb_clock_gen_i (
        .clk (clk),
        .rst (rst)
    );

    mem_stage_top #(.ADDR_W(32)) mem_stage_top_i (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_data        (in_data),
        .in_ready       (in_ready),
        .out_valid      (out_valid),
        .out_data       (out_data),
        .out_ready      (out_ready),
        .wb_fwd         (wb_fwd),
        .dmem_req_valid (dmem_req_valid),
        .dmem_req       (dmem_req),
        .dmem_rsp_valid (dmem_rsp_valid),
        .dmem_rsp_rdata (dmem_rsp_rdata)
    );

    // ******************************
    // random source
    // ******************************
    function automatic logic next_bit();
        logic lsb;
        lsb = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) lfsr_state = lfsr_state ^ 16'hB400;   // galois taps 16,14,13,11
        return lsb;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) r[i] = next_bit();
        return r;
    endfunction

    // ******************************
    // reference model
    // ******************************
    function automatic exp_t exp_result(input mem_stage_pkg::ex_mem_t d,
                                        input mem_stage_pkg::wb_fwd_t f,
                                        input logic [63:0] dword);
        exp_t        e;
        logic [63:0] op;
        logic [63:0] val;
        logic [63:0] v;
        logic [2:0]  off;
        logic [2:0]  f3;
        logic [4:0]  rs2;
        int          nbytes;
        e      = '0;
        off    = d.alu_out[2:0];
        f3     = d.inst.i_fmt.funct3;
        rs2    = d.inst.s_fmt.rs2;
        nbytes = 1 << f3[1:0];
        // WB result wins over the stale ID read
        op     = (f.valid && f.wen && f.rd == rs2 && rs2 != 5'd0) ? f.wdata : d.src2;
        e.addr = {32'h0, d.alu_out[31:0]};
        e.wen  = (d.mem_kind == mem_stage_pkg::MEM_STORE);
        if (e.wen) begin
            for (int i = 0; i < nbytes; i++) begin
                e.wstrb[off + i]          = 1'b1;
                e.wdata[(off + i) * 8 +: 8] = op[i * 8 +: 8];
            end
        end
        val = '0;
        for (int i = 0; i < nbytes; i++) val[i * 8 +: 8] = dword[(off + i) * 8 +: 8];
        if (!f3[2] && nbytes < 8 && val[nbytes * 8 - 1]) begin   // sign fill
            for (int j = nbytes * 8; j < 64; j++) val[j] = 1'b1;
        end
        case (d.wb_src)
            mem_stage_pkg::WB_ALU:  v = d.alu_out;
            mem_stage_pkg::WB_LOAD: v = val;
            mem_stage_pkg::WB_LINK: v = d.pc + 64'd4;
            default:                v = '0;
        endcase
        e.reg_wr.wen   = (d.wb_src != mem_stage_pkg::WB_NONE);
        e.reg_wr.rd    = e.reg_wr.wen ? d.inst.i_fmt.rd : 5'd0;
        e.reg_wr.value = e.reg_wr.wen ? v : 64'd0;
        return e;
    endfunction

    // ******************************
    // stimulus
    // ******************************
    task automatic gen_item();
        mem_stage_pkg::ex_mem_t d;
        logic [63:0] r;
        logic [2:0]  pick;
        logic [1:0]  sz;
        logic [7:0]  a8;
        d      = '0;
        r      = rand_bits(62);
        d.pc   = {r[61:0], 2'b00};
        r      = rand_bits(32);
        d.inst = r[31:0];
        d.src2 = rand_bits(64);
        r      = rand_bits(3);
        pick   = r[2:0];
        r      = rand_bits(2);
        sz     = r[1:0];
        r      = rand_bits(8);
        a8     = r[7:0];
        case (sz)                                   // natural alignment only
            2'd1:    a8[0]   = 1'b0;
            2'd2:    a8[1:0] = 2'b00;
            2'd3:    a8[2:0] = 3'b000;
            default: a8      = a8;
        endcase
        r = rand_bits(5);
        d.inst.i_fmt.rd = r[4:0];
        if (pick >= 3'd4) begin
            r = rand_bits(32);                      // junk above ADDR_W
            d.alu_out = {r[31:0], 16'h0000, 8'h10, a8};
        end else begin
            d.alu_out = rand_bits(64);
        end
        case (pick)
            3'd0, 3'd1: begin
                d.inst.i_fmt.opcode = 7'b0010011;
                d.wb_src            = mem_stage_pkg::WB_ALU;
            end
            3'd2: begin
                d.inst.i_fmt.opcode = 7'b1101111;   // jal
                d.wb_src            = mem_stage_pkg::WB_LINK;
            end
            3'd3: begin
                d.inst.i_fmt.opcode = 7'b1100011;   // branch, no write
                d.wb_src            = mem_stage_pkg::WB_NONE;
            end
            3'd4, 3'd5: begin
                r = rand_bits(1);
                d.inst.i_fmt.opcode = 7'b0000011;
                d.inst.i_fmt.funct3 = {(sz != 2'd3) & r[0], sz};
                d.mem_kind          = mem_stage_pkg::MEM_LOAD;
                d.wb_src            = mem_stage_pkg::WB_LOAD;
            end
            default: begin
                r = rand_bits(2);                   // few registers, many fwd hits
                d.inst.s_fmt.opcode = 7'b0100011;
                d.inst.s_fmt.funct3 = {1'b0, sz};
                d.inst.s_fmt.rs2    = {3'b000, r[1:0]};
                d.mem_kind          = mem_stage_pkg::MEM_STORE;
                d.wb_src            = mem_stage_pkg::WB_NONE;
            end
        endcase
        in_data = d;
        r = rand_bits(4);
        drv_fwd.valid = r[0];
        drv_fwd.wen   = r[1];
        drv_fwd.rd    = {3'b000, r[3:2]};
        drv_fwd.wdata = rand_bits(64);
    endtask

    initial begin : drive
        int warmup;
        warmup         = 4;                         // idle check window after reset
        in_valid       = 1'b0;
        in_data        = '0;
        out_ready      = 1'b0;
        wb_fwd         = '0;
        drv_fwd        = '0;
        dmem_rsp_valid = 1'b0;
        dmem_rsp_rdata = '0;
        for (int a = 0; a < 256; a++) begin
            mem[a / 8][(a % 8) * 8 +: 8] = a[7:0] * 8'd37 + 8'd11;   // per byte address
        end
        forever begin
            @(posedge clk);
            #5;
            dmem_rsp_valid = 1'b0;
            if (rsp_pending) begin
                rsp_lat--;
                if (rsp_lat == 0) begin
                    dmem_rsp_valid = 1'b1;
                    dmem_rsp_rdata = rsp_data;
                    rsp_pending    = 1'b0;
                end
            end
            if (!rst) begin
                out_ready = (rand_bits(2) != 64'd0);   // high 3 of 4 cycles
                if (took_item) wb_fwd = drv_fwd;       // tracks the item now held
                if (!in_valid || took_item) begin
                    if (warmup > 0) begin
                        warmup--;
                        in_valid = 1'b0;
                    end else if (gen_cnt < N_ITEMS && rand_bits(3) != 64'd0) begin
                        gen_item();
                        in_valid = 1'b1;
                        gen_cnt++;
                    end else begin
                        in_valid = 1'b0;               // bubble
                    end
                end
                took_item = 1'b0;
            end
        end
    end

    // ******************************
    // monitor and comparison
    // ******************************
    always @(negedge clk) begin : compare
        item_rec_t   rec;
        exp_t        e;
        logic [63:0] mask;
        logic [63:0] dword;
        if (!rst) begin
            if (!first_in_seen) begin
                assert (!out_valid && !dmem_req_valid) else begin
                    chk_errs++;
                    $display("[FAIL] %0t ns: output active before any input", $time);
                end
                first_in_seen = in_valid;
            end
            assert (out_valid || !out_data.reg_wr.wen) else begin
                chk_errs++;
                $display("[FAIL] %0t ns: reg write enabled without out_valid", $time);
            end
            // no intake from capture of a memory item until its response
            assert (in_ready == (out_ready && !mem_busy)) else begin
                chk_errs++;
                $display("[FAIL] %0t ns: in_ready %b, expected %b",
                         $time, in_ready, out_ready && !mem_busy);
            end
            if (dmem_req_valid) begin
                req_cnt++;
                assert (!outstanding) else begin
                    proto_errs++;
                    $display("memory request issued at %0t ns while another is outstanding",
                             $time);
                end
                assert (memq.size() > 0) else begin
                    proto_errs++;
                    $display("memory request at %0t ns with no memory item held", $time);
                end
                if (memq.size() > 0) begin
                    rec  = memq.pop_front();
                    e    = exp_result(rec.item, rec.fwd, mem[rec.item.alu_out[7:3]]);
                    mask = '0;
                    for (int i = 0; i < 8; i++) mask[i * 8 +: 8] = {8{e.wstrb[i]}};
                    assert (dmem_req.addr == e.addr && dmem_req.wen == e.wen) else begin
                        chk_errs++;
                        $display("[FAIL] %0t ns: request addr %h wen %b, expected %h %b",
                                 $time, dmem_req.addr, dmem_req.wen, e.addr, e.wen);
                    end
                    assert (dmem_req.wstrb == e.wstrb
                            && ((dmem_req.wdata ^ e.wdata) & mask) == 64'd0) else begin
                        chk_errs++;
                        $display("[FAIL] %0t ns: store data %h strb %h, expected %h %h",
                                 $time, dmem_req.wdata, dmem_req.wstrb, e.wdata, e.wstrb);
                    end
                    snap_q.push_back(mem[rec.item.alu_out[7:3]]);
                    rsp_data = mem[dmem_req.addr[7:3]];
                    if (dmem_req.wen) begin
                        for (int i = 0; i < 8; i++) begin
                            if (dmem_req.wstrb[i]) begin
                                mem[dmem_req.addr[7:3]][i * 8 +: 8] = dmem_req.wdata[i * 8 +: 8];
                            end
                        end
                    end
                    outstanding = 1'b1;
                    rsp_pending = 1'b1;
                    rsp_lat     = 1 + int'(rand_bits(2));   // 1..4 cycles
                end
            end
            if (dmem_rsp_valid) begin
                outstanding = 1'b0;
                mem_busy    = 1'b0;     // item free to leave next cycle
            end
            if (out_valid && out_ready) begin
                assert (acc_q.size() > 0) else begin
                    proto_errs++;
                    $display("output transfer at %0t ns with no item in flight", $time);
                end
                if (acc_q.size() > 0) begin
                    rec   = acc_q.pop_front();
                    dword = '0;
                    if (rec.item.mem_kind != mem_stage_pkg::MEM_NONE) begin
                        assert (snap_q.size() > 0) else begin
                            proto_errs++;
                            $display("memory item left at %0t ns without a request", $time);
                        end
                        if (snap_q.size() > 0) begin
                            dword = snap_q.pop_front();
                        end
                    end
                    e = exp_result(rec.item, rec.fwd, dword);
                    assert (out_data.pc == rec.item.pc && out_data.inst == rec.item.inst)
                    else begin
                        chk_errs++;
                        $display("[FAIL] %0t ns: item out of order, pc %h expected %h",
                                 $time, out_data.pc, rec.item.pc);
                    end
                    assert (out_data.reg_wr == e.reg_wr) else begin
                        chk_errs++;
                        $display("[FAIL] %0t ns: reg_wr %b x%0d %h, expected %b x%0d %h",
                                 $time, out_data.reg_wr.wen, out_data.reg_wr.rd,
                                 out_data.reg_wr.value, e.reg_wr.wen, e.reg_wr.rd,
                                 e.reg_wr.value);
                    end
                    done_cnt++;
                end
            end
            if (in_valid && in_ready) begin
                acc_q.push_back({in_data, drv_fwd});
                if (in_data.mem_kind != mem_stage_pkg::MEM_NONE) begin
                    memq.push_back({in_data, drv_fwd});
                    mem_items++;
                    mem_busy = 1'b1;    // stall starts once it is held
                end
                took_item = 1'b1;
            end
        end
    end

    // ******************************
    // end of run
    // ******************************
    initial begin : finish_run
        @(negedge rst);
        while (done_cnt < N_ITEMS) @(posedge clk);
        repeat (5) @(posedge clk);
        assert (req_cnt == mem_items && memq.size() == 0 && !outstanding) else begin
            proto_errs++;
            $display("requests issued %0d for %0d memory items", req_cnt, mem_items);
        end
        $display("items %0d, check errors %0d, protocol errors %0d",
                 done_cnt, chk_errs, proto_errs);
        if (chk_errs == 0 && proto_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(WD_LIMIT);
        $display("timeout, only %0d of %0d items completed", done_cnt, N_ITEMS);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
/*
 * testbench clock and reset
 * free running clock, reset held for a fixed number of cycles
 */

`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD     = 100,    // ns
    parameter int RST_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release a little after the edge, like every other input
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #5 rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: design/mem_stage_top.sv
/*
 * memory-access stage of the rv64 in-order pipeline
 * stage register, store formatting, memory port control and write-back select
 */

`timescale 1ns/10ps
`default_nettype none

module mem_stage_top #(
    parameter int ADDR_W = 32
) (
    input  logic                               clk,
    input  logic                               rst,
    // EX side
    input  logic                               in_valid,
    input  mem_stage_pkg::ex_mem_t             in_data,
    output logic                               in_ready,
    // WB side
    output logic                               out_valid,
    output mem_stage_pkg::mem_wb_t             out_data,
    input  logic                               out_ready,
    input  mem_stage_pkg::wb_fwd_t             wb_fwd,
    // data memory
    output logic                               dmem_req_valid,
    output mem_stage_pkg::dmem_req_t           dmem_req,
    input  logic                               dmem_rsp_valid,
    input  logic [mem_stage_pkg::XLEN-1:0]     dmem_rsp_rdata
);

    // ******************************
    // internal wires
    // ******************************
    logic                                stage_valid;
    mem_stage_pkg::ex_mem_t              stage_data;
    logic                                stall;
    logic [mem_stage_pkg::XLEN-1:0]      wdata;        // lane-placed store data
    logic [mem_stage_pkg::STRB_W-1:0]    wstrb;
    logic [mem_stage_pkg::XLEN-1:0]      load_word;    // raw dword from memory
    logic                                item_leaving;

    assign item_leaving = out_valid && out_ready;      // handshake to WB

    // ******************************
    // instances
    // ******************************
    mem_stage_reg mem_stage_reg_i (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .in_ready    (in_ready),
        .stall       (stall),
        .out_ready   (out_ready),
        .stage_valid (stage_valid),
        .stage_data  (stage_data)
    );

    store_data_unit store_data_unit_i (
        .stage_data (stage_data),
        .wb_fwd     (wb_fwd),
        .wdata      (wdata),
        .wstrb      (wstrb)
    );

    mem_access_ctrl #(
        .ADDR_W (ADDR_W)
    ) mem_access_ctrl_i (
        .clk            (clk),
        .rst            (rst),
        .stage_valid    (stage_valid),
        .stage_data     (stage_data),
        .wdata          (wdata),
        .wstrb          (wstrb),
        .item_leaving   (item_leaving),
        .stall          (stall),
        .dmem_req_valid (dmem_req_valid),
        .dmem_req       (dmem_req),
        .dmem_rsp_valid (dmem_rsp_valid),
        .dmem_rsp_rdata (dmem_rsp_rdata),
        .load_word      (load_word)
    );

    wb_result_unit wb_result_unit_i (
        .stage_valid (stage_valid),
        .stall       (stall),
        .stage_data  (stage_data),
        .load_word   (load_word),
        .out_valid   (out_valid),
        .out_data    (out_data)
    );

endmodule

`default_nettype wire

// File: design/wb_result_unit.sv
/*
 * write-back result
 * load extraction with sign/zero extension, write value select,
 * output valid and register write gated by the stall
 */

`timescale 1ns/10ps
`default_nettype none

module wb_result_unit (
    input  logic                             stage_valid,
    input  logic                             stall,
    input  mem_stage_pkg::ex_mem_t           stage_data,
    input  logic [mem_stage_pkg::XLEN-1:0]   load_word,
    output logic                             out_valid,
    output mem_stage_pkg::mem_wb_t           out_data
);

    localparam int XL = mem_stage_pkg::XLEN;

    logic [XL-1:0]            shifted;
    logic [XL-1:0]            load_val;
    logic [XL-1:0]            wb_val;
    logic                     is_unsigned;
    mem_stage_pkg::mem_size_e size;
    logic                     wen;

    // ******************************
    // load extraction
    // ******************************
    assign shifted     = load_word >> {stage_data.alu_out[2:0], 3'b000};   // lane to bit 0
    assign is_unsigned = stage_data.inst.i_fmt.funct3[2];                  // lbu lhu lwu
    assign size        = mem_stage_pkg::mem_size_e'(stage_data.inst.i_fmt.funct3[1:0]);

    always_comb begin
        case (size)
            mem_stage_pkg::SZ_B:
                load_val = {{(XL-8){shifted[7] & ~is_unsigned}}, shifted[7:0]};
            mem_stage_pkg::SZ_H:
                load_val = {{(XL-16){shifted[15] & ~is_unsigned}}, shifted[15:0]};
            mem_stage_pkg::SZ_W:
                load_val = {{(XL-32){shifted[31] & ~is_unsigned}}, shifted[31:0]};
            default:
                load_val = shifted;                                        // ld
        endcase
    end

    // ******************************
    // write value and output
    // ******************************
    always_comb begin
        case (stage_data.wb_src)
            mem_stage_pkg::WB_ALU:  wb_val = stage_data.alu_out;
            mem_stage_pkg::WB_LOAD: wb_val = load_val;
            mem_stage_pkg::WB_LINK: wb_val = stage_data.pc + 64'd4;        // return address
            default:                wb_val = '0;
        endcase
    end

    assign out_valid = stage_valid && !stall;
    assign wen       = out_valid && (stage_data.wb_src != mem_stage_pkg::WB_NONE);

    assign out_data.pc           = stage_data.pc;
    assign out_data.inst         = stage_data.inst;
    assign out_data.reg_wr.wen   = wen;
    assign out_data.reg_wr.rd    = wen ? stage_data.inst.i_fmt.rd : '0;   // quiet when idle
    assign out_data.reg_wr.value = wen ? wb_val : '0;

endmodule

`default_nettype wire

// File: design/mem_access_ctrl.sv
/*
 * data memory access control
 * one request per load/store, waits for the response, latches the
 * read data and stalls the stage until the item can move on
 */

`timescale 1ns/10ps
`default_nettype none

module mem_access_ctrl #(
    parameter int ADDR_W = 32                        // physical address bits
) (
    input  logic                                 clk,
    input  logic                                 rst,
    // held item
    input  logic                                 stage_valid,
    input  mem_stage_pkg::ex_mem_t               stage_data,
    input  logic [mem_stage_pkg::XLEN-1:0]       wdata,
    input  logic [mem_stage_pkg::STRB_W-1:0]     wstrb,
    input  logic                                 item_leaving,
    output logic                                 stall,
    // memory port
    output logic                                 dmem_req_valid,
    output mem_stage_pkg::dmem_req_t             dmem_req,
    input  logic                                 dmem_rsp_valid,
    input  logic [mem_stage_pkg::XLEN-1:0]       dmem_rsp_rdata,
    // latched read data
    output logic [mem_stage_pkg::XLEN-1:0]       load_word
);

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_WAIT = 2'd1,    // request out, response pending
        ST_DONE = 2'd2     // response in, item waits for WB
    } state_e;

    state_e state;
    state_e state_nxt;
    logic   mem_item;

    assign mem_item = stage_valid && (stage_data.mem_kind != mem_stage_pkg::MEM_NONE);

    // ******************************
    // FSM
    // ******************************
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: if (mem_item)       state_nxt = ST_WAIT;   // request goes out now
            ST_WAIT: if (dmem_rsp_valid) state_nxt = ST_DONE;
            ST_DONE: if (item_leaving)   state_nxt = ST_IDLE;
            default:                     state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // read data, kept until the item leaves
    always_ff @(posedge clk) begin
        if ((state == ST_WAIT) && dmem_rsp_valid) begin
            load_word <= dmem_rsp_rdata;
        end
    end

    // ******************************
    // request and stall
    // ******************************
    assign dmem_req_valid = (state == ST_IDLE) && mem_item;    // single cycle strobe

    always_comb begin
        dmem_req             = '0;
        dmem_req.addr[ADDR_W-1:0] = stage_data.alu_out[ADDR_W-1:0];   // upper bits dropped
        dmem_req.wen         = (stage_data.mem_kind == mem_stage_pkg::MEM_STORE);
        dmem_req.wdata       = wdata;
        dmem_req.wstrb       = wstrb;      // zero for loads
    end

    // stalled from capture until the response is in
    assign stall = mem_item && (state != ST_DONE);

endmodule

`default_nettype wire

// File: design/store_data_unit.sv
/*
 * store data formatting
 * picks rs2 (forwarded from WB when it matches), places it in the
 * byte lanes and builds the byte strobe
 */

`timescale 1ns/10ps
`default_nettype none

module store_data_unit (
    input  mem_stage_pkg::ex_mem_t               stage_data,
    input  mem_stage_pkg::wb_fwd_t               wb_fwd,
    output logic [mem_stage_pkg::XLEN-1:0]       wdata,
    output logic [mem_stage_pkg::STRB_W-1:0]     wstrb
);

    logic                                  fwd_hit;
    logic [mem_stage_pkg::XLEN-1:0]        store_op;
    logic [2:0]                            offset;
    mem_stage_pkg::mem_size_e              size;
    logic [mem_stage_pkg::STRB_W-1:0]      base_strb;
    logic                                  is_store;

    // ******************************
    // rs2 forwarding
    // ******************************
    // WB writes the register this store reads, x0 never forwards
    assign fwd_hit = wb_fwd.valid && wb_fwd.wen
                     && (wb_fwd.rd == stage_data.inst.s_fmt.rs2)
                     && (stage_data.inst.s_fmt.rs2 != '0);

    assign store_op = fwd_hit ? wb_fwd.wdata : stage_data.src2;

    assign offset   = stage_data.alu_out[2:0];           // byte within dword
    assign size     = mem_stage_pkg::mem_size_e'(stage_data.inst.s_fmt.funct3[1:0]);
    assign is_store = (stage_data.mem_kind == mem_stage_pkg::MEM_STORE);

    // ******************************
    // lane placement
    // ******************************
    // value copied to every lane, the strobe says which one counts
    always_comb begin
        case (size)
            mem_stage_pkg::SZ_B: begin
                wdata     = {mem_stage_pkg::STRB_W{store_op[7:0]}};
                base_strb = 8'b0000_0001;
            end
            mem_stage_pkg::SZ_H: begin
                wdata     = {(mem_stage_pkg::STRB_W / 2){store_op[15:0]}};
                base_strb = 8'b0000_0011;
            end
            mem_stage_pkg::SZ_W: begin
                wdata     = {(mem_stage_pkg::STRB_W / 4){store_op[31:0]}};
                base_strb = 8'b0000_1111;
            end
            default: begin                                // sd
                wdata     = store_op;
                base_strb = 8'b1111_1111;
            end
        endcase
    end

    // natural alignment assumed, the shift never runs off the top
    // no lanes for loads or plain ALU items
    assign wstrb = is_store ? (base_strb << offset) : '0;

endmodule

`default_nettype wire

// File: design/mem_stage_reg.sv
/*
 * EX/MEM stage register
 * holds one instruction, stays put while stalled or blocked by WB
 */

`timescale 1ns/10ps
`default_nettype none

module mem_stage_reg (
    input  logic                   clk,
    input  logic                   rst,
    // from EX
    input  logic                   in_valid,
    input  mem_stage_pkg::ex_mem_t in_data,
    output logic                   in_ready,
    // hold control
    input  logic                   stall,
    input  logic                   out_ready,
    // held item
    output logic                   stage_valid,
    output mem_stage_pkg::ex_mem_t stage_data
);

    // ******************************
    // ready
    // ******************************
    // a stalled item never leaves, so nothing may be taken in
    assign in_ready = stall ? 1'b0 : out_ready;

    // ******************************
    // valid bit
    // ******************************
    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= 1'b0;
        end else if (in_ready) begin
            stage_valid <= in_valid;     // new item or bubble
        end
    end

    // payload, only the valid bit matters after reset
    always_ff @(posedge clk) begin
        if (in_ready) begin
            stage_data <= in_data;
        end
    end

endmodule

`default_nettype wire

// File: design/mem_stage_pkg.sv
/*
 * memory-access stage shared definitions
 * widths, operation enums, instruction views and the stage payload structs
 */

`default_nettype none

package mem_stage_pkg;

    // ******************************
    // widths
    // ******************************
    parameter int XLEN       = 64;           // rv64 data path
    parameter int STRB_W     = XLEN / 8;     // one strobe bit per byte lane
    parameter int REG_ADDR_W = 5;            // x0..x31

    // ******************************
    // operation encodings
    // ******************************
    // memory operation sent down from EX
    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_kind_e;

    // funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        SZ_B = 2'd0,
        SZ_H = 2'd1,
        SZ_W = 2'd2,
        SZ_D = 2'd3
    } mem_size_e;

    // where the register write value comes from
    typedef enum logic [1:0] {
        WB_NONE = 2'd0,    // no register write
        WB_ALU  = 2'd1,
        WB_LOAD = 2'd2,
        WB_LINK = 2'd3     // jal / jalr, pc+4
    } wb_src_e;

    // ******************************
    // instruction word views
    // ******************************
    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [REG_ADDR_W-1:0] rs2;      // store data register
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } s_fmt_t;

    // loads and write-back read it as I-type, stores as S-type
    typedef union packed {
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
    } rv_inst_u;

    // ******************************
    // stage payloads
    // ******************************
    typedef struct packed {
        logic [XLEN-1:0] pc;
        rv_inst_u        inst;
        logic [XLEN-1:0] alu_out;     // result, or effective address for ld/st
        logic [XLEN-1:0] src2;        // rs2 value as read in ID
        mem_kind_e       mem_kind;
        wb_src_e         wb_src;
    } ex_mem_t;

    typedef struct packed {
        logic                  valid;
        logic                  wen;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       wdata;
    } wb_fwd_t;

    typedef struct packed {
        logic                  wen;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       value;
    } reg_wr_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        rv_inst_u        inst;
        reg_wr_t         reg_wr;
    } mem_wb_t;

    // addr carried full width, upper bits zero above ADDR_W
    typedef struct packed {
        logic [XLEN-1:0]   addr;
        logic              wen;
        logic [XLEN-1:0]   wdata;
        logic [STRB_W-1:0] wstrb;
    } dmem_req_t;

endpackage

`default_nettype wire
